//--- hw/int_div_pkg.sv
/*
  integer divider shared definitions
  widths, step count, function encoding and the bundles passed between blocks
*/

package int_div_pkg;

  // --------------------
  // sizes
  // --------------------

  // operand and result word width
  localparam int data_width = 32;

  // one restoring step per quotient bit
  localparam int step_count = 32;

  // wide enough to count 0 .. step_count-1
  localparam int count_width = 5;

  // --------------------
  // function encoding
  // --------------------

  typedef enum logic {
    fn_unsigned = 1'b0,
    fn_signed   = 1'b1
  } div_fn_e;

  // --------------------
  // bundles
  // --------------------

  // request word, fn sits in the top bit
  typedef struct packed {
    div_fn_e               fn;
    logic [data_width-1:0] a;
    logic [data_width-1:0] b;
  } div_req_t;

  // response word, remainder in the upper half
  typedef struct packed {
    logic [data_width-1:0] rem;
    logic [data_width-1:0] quot;
  } div_resp_t;

  // unsigned operands handed to the step unit
  typedef struct packed {
    logic [data_width-1:0] dividend_mag;
    logic [data_width-1:0] divisor_mag;
  } div_operands_t;

  // sign fixes applied after the last step
  typedef struct packed {
    logic quot_neg;
    logic rem_neg;
  } div_signs_t;

endpackage

//--- hw/int_div_ctrl.sv
/*
  divider control FSM
  sequences idle, calc and done and drives the val/rdy handshake
*/

`timescale 1ns/1ps

module int_div_ctrl (
  input  logic clk,
  input  logic reset,
  input  logic req_val,
  input  logic resp_rdy,
  output logic req_rdy,
  output logic resp_val,
  output logic load,
  output logic step
);

  import int_div_pkg::*;

  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_calc = 2'd1,
    st_done = 2'd2
  } state_e;

  state_e state_q;
  state_e state_d;

  // index of the step being performed this cycle
  logic [count_width-1:0] count_q;

  logic last_step;
  logic resp_xfer;

  // --------------------
  // handshake decode
  // --------------------

  // levels come from state alone
  assign req_rdy  = (state_q == st_idle);
  assign resp_val = (state_q == st_done);

  // load pulses on the accepting edge only
  assign load = req_rdy & req_val;

  // one shift-subtract per calc cycle
  assign step = (state_q == st_calc);

  assign resp_xfer = resp_val & resp_rdy;

  // final step happens on the edge that ends this cycle
  assign last_step = step && (count_q == count_width'(step_count - 1));

  // --------------------
  // next state
  // --------------------

  always_comb begin
    state_d = state_q;
    case (state_q)
      st_idle: begin
        if (load) begin
          state_d = st_calc;
        end
      end
      st_calc: begin
        if (last_step) begin
          state_d = st_done;
        end
      end
      st_done: begin
        // hold the response until the consumer takes it
        if (resp_xfer) begin
          state_d = st_idle;
        end
      end
      default: begin
        state_d = st_idle;
      end
    endcase
  end

  // --------------------
  // state and counter
  // --------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= st_idle;
      count_q <= '0;
    end else begin
      state_q <= state_d;
      if (load) begin
        // restart the step count for the new division
        count_q <= '0;
      end else if (step) begin
        // wraps to zero after the last step
        count_q <= count_q + 1'b1;
      end
    end
  end

endmodule

//--- hw/div_operand_prep.sv
/*
  operand preparation for the divider
  forms unsigned magnitudes and latches the result sign flags on load
*/

`timescale 1ns/1ps

module div_operand_prep (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       load,
  input  int_div_pkg::div_req_t      req,
  output int_div_pkg::div_operands_t operands,
  output int_div_pkg::div_signs_t    signs
);

  import int_div_pkg::*;

  logic       is_signed;
  logic       a_neg;
  logic       b_neg;
  div_signs_t signs_d;
  div_signs_t signs_q;

  // --------------------
  // magnitudes
  // --------------------

  assign is_signed = (req.fn == fn_signed);

  // an operand counts as negative only for signed division
  assign a_neg = is_signed & req.a[data_width-1];
  assign b_neg = is_signed & req.b[data_width-1];

  // two's complement magnitude, most negative value maps onto itself
  assign operands.dividend_mag = a_neg ? (~req.a + 1'b1) : req.a;
  assign operands.divisor_mag  = b_neg ? (~req.b + 1'b1) : req.b;

  // --------------------
  // result signs
  // --------------------

  // quotient negative when exactly one operand is negative
  assign signs_d.quot_neg = a_neg ^ b_neg;

  // remainder takes the sign of the dividend
  assign signs_d.rem_neg = a_neg;

  // req may change once accepted, so keep the flags for the whole division
  always_ff @(posedge clk) begin
    if (reset) begin
      signs_q <= '0;
    end else if (load) begin
      signs_q <= signs_d;
    end
  end

  assign signs = signs_q;

endmodule

//--- hw/div_step_unit.sv
/*
  restoring divide datapath
  one shift-subtract step per cycle on a 65-bit remainder/quotient register
*/

`timescale 1ns/1ps

module div_step_unit (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       load,
  input  logic                       step,
  input  int_div_pkg::div_operands_t operands,
  output int_div_pkg::div_resp_t     mags
);

  import int_div_pkg::*;

  // partial remainder in the upper bits, dividend/quotient in the low bits
  logic [2*data_width:0]   rq_q;
  logic [data_width-1:0]   divisor_q;

  logic [2*data_width:0]   rq_shift;
  logic [2*data_width:0]   divisor_aligned;
  logic [2*data_width:0]   diff;
  logic [2*data_width:0]   rq_next;

  // --------------------
  // one restoring step
  // --------------------

  assign rq_shift = rq_q << 1;

  // divisor sits in bits 63:32
  assign divisor_aligned = {1'b0, divisor_q, {data_width{1'b0}}};

  assign diff = rq_shift - divisor_aligned;

  // top bit of the difference tells whether the subtract went negative
  always_comb begin
    if (diff[2*data_width]) begin
      // restore, quotient bit stays zero from the shift
      rq_next = rq_shift;
    end else begin
      // keep the difference and shift in a one
      rq_next = {diff[2*data_width:1], 1'b1};
    end
  end

  // --------------------
  // registers
  // --------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      rq_q <= '0;
    end else if (load) begin
      rq_q <= {{(data_width+1){1'b0}}, operands.dividend_mag};
    end else if (step) begin
      rq_q <= rq_next;
    end
  end

  // only changes on a new request
  always_ff @(posedge clk) begin
    if (load) begin
      divisor_q <= operands.divisor_mag;
    end
  end

  // bit 64 is always clear once a step has settled
  assign mags.rem  = rq_q[2*data_width-1:data_width];
  assign mags.quot = rq_q[data_width-1:0];

endmodule

//--- hw/div_result_fix.sv
/*
  divider sign fix-up
  negates quotient and remainder magnitudes and forms the response word
*/

`timescale 1ns/1ps

module div_result_fix (
  input  int_div_pkg::div_resp_t  mags,
  input  int_div_pkg::div_signs_t signs,
  output int_div_pkg::div_resp_t  resp
);

  import int_div_pkg::*;

  logic [data_width-1:0] quot_negated;
  logic [data_width-1:0] rem_negated;

  // --------------------
  // negation
  // --------------------

  // two's complement of each magnitude
  assign quot_negated = ~mags.quot + 1'b1;
  assign rem_negated  = ~mags.rem + 1'b1;

  // quotient sign is the xor of the operand signs
  assign resp.quot = signs.quot_neg ? quot_negated : mags.quot;

  // remainder follows the dividend, so a == q*b + r holds
  assign resp.rem = signs.rem_neg ? rem_negated : mags.rem;

endmodule

//--- hw/int_div_iterative.sv
/*
  iterative 32-bit integer divider
  signed or unsigned, one quotient bit per cycle, val/rdy on both sides
*/

`timescale 1ns/1ps

module int_div_iterative (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   req_val,
  input  logic                   resp_rdy,
  input  int_div_pkg::div_req_t  req,
  output logic                   req_rdy,
  output logic                   resp_val,
  output int_div_pkg::div_resp_t resp
);

  import int_div_pkg::*;

  // control to datapath
  logic load;
  logic step;

  // datapath between stages
  div_operands_t operands;
  div_signs_t    signs;
  div_resp_t     mags;

  // --------------------
  // control
  // --------------------

  int_div_ctrl ctrl0 (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .resp_rdy (resp_rdy),
    .req_rdy  (req_rdy),
    .resp_val (resp_val),
    .load     (load),
    .step     (step)
  );

  // --------------------
  // datapath
  // --------------------

  div_operand_prep prep0 (
    .clk      (clk),
    .reset    (reset),
    .load     (load),
    .req      (req),
    .operands (operands),
    .signs    (signs)
  );

  div_step_unit step0 (
    .clk      (clk),
    .reset    (reset),
    .load     (load),
    .step     (step),
    .operands (operands),
    .mags     (mags)
  );

  // combinational, valid whenever resp_val is high
  div_result_fix fix0 (
    .mags  (mags),
    .signs (signs),
    .resp  (resp)
  );

endmodule

//--- verif/int_div_assertions.sv
/*
  handshake checks for the iterative divider
*/

`timescale 1ns/1ps

module int_div_assertions (
  input logic                   clk,
  input logic                   reset,
  input logic                   req_val,
  input logic                   req_rdy,
  input logic                   resp_val,
  input logic                   resp_rdy,
  input int_div_pkg::div_resp_t resp
);

  // --------------------
  // handshake properties
  // --------------------

  // idle and done are exclusive states
  rdy_val_exclusive: assert property (@(posedge clk) disable iff (reset)
    !(req_rdy && resp_val))
    else $error("req_rdy and resp_val high in the same cycle");

  // response may not be withdrawn before the consumer takes it
  resp_val_held: assert property (@(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> resp_val)
    else $error("resp_val dropped without a transfer");

  // data frozen under back-pressure
  resp_stable: assert property (@(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> $stable(resp))
    else $error("resp changed while stalled");

  // one division in flight, so no second accept right away
  req_rdy_falls: assert property (@(posedge clk) disable iff (reset)
    (req_val && req_rdy) |=> !req_rdy)
    else $error("req_rdy still high after an accepting edge");

endmodule

bind int_div_iterative int_div_assertions asrt0 (.*);

//--- verif/int_div_iterative_tb.sv
/*
  directed testbench for the iterative divider
  drives requests, stalls the response side and checks against a reference model
*/

`timescale 1ns/1ps

module int_div_iterative_tb;

  import int_div_pkg::*;

  localparam int clk_period   = 20;
  localparam int reset_cycles = 10;
  localparam int max_stall    = 8;
  localparam int seed         = 34;
  // operations per test, sizes the watchdog
  localparam int num_ops      = 8 + 8 + 5 + 2 + 200;
  localparam longint watchdog_ns =
    2 * (num_ops * (step_count + 1 + max_stall + 2) + reset_cycles) * clk_period;

  logic      clk;
  logic      reset;
  logic      req_val;
  logic      req_rdy;
  logic      resp_val;
  logic      resp_rdy;
  div_req_t  req;
  div_resp_t resp;

  int_div_iterative dut0 (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .resp_rdy (resp_rdy),
    .req      (req),
    .req_rdy  (req_rdy),
    .resp_val (resp_val),
    .resp     (resp)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  initial begin
    #(watchdog_ns);
    $display("timeout, the divider stopped responding");
    $display("TESTBENCH FAILED");
    $fatal(1, "watchdog expired");
  end

  // --------------------
  // helpers
  // --------------------

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TESTBENCH FAILED");
    $fatal(1, "first error, run stopped");
  endtask

  function automatic div_req_t make_req(input div_fn_e fn, input logic [data_width-1:0] a,
                                        input logic [data_width-1:0] b);
    div_req_t r;
    r.fn = fn;
    r.a  = a;
    r.b  = b;
    return r;
  endfunction

  function automatic div_resp_t make_resp(input logic [data_width-1:0] rem,
                                          input logic [data_width-1:0] quot);
    div_resp_t e;
    e.rem  = rem;
    e.quot = quot;
    return e;
  endfunction

  function automatic div_fn_e random_fn();
    logic pick;
    pick = 1'($urandom);
    return pick ? fn_signed : fn_unsigned;
  endfunction

  // reference model, magnitudes then sign fix
  function automatic div_resp_t model_div(input div_req_t r);
    logic                  a_neg;
    logic                  b_neg;
    logic [data_width-1:0] a_mag;
    logic [data_width-1:0] b_mag;
    logic [data_width-1:0] q_mag;
    logic [data_width-1:0] r_mag;
    a_neg = (r.fn == fn_signed) && r.a[data_width-1];
    b_neg = (r.fn == fn_signed) && r.b[data_width-1];
    a_mag = a_neg ? -r.a : r.a;
    b_mag = b_neg ? -r.b : r.b;
    if (b_mag == '0) begin
      // restoring rule with a zero divisor
      q_mag = '1;
      r_mag = a_mag;
    end else begin
      q_mag = a_mag / b_mag;
      r_mag = a_mag % b_mag;
    end
    return make_resp(a_neg ? -r_mag : r_mag, (a_neg != b_neg) ? -q_mag : q_mag);
  endfunction

  // --------------------
  // compare tasks
  // --------------------

  task automatic compare_resp(input div_req_t r, input div_resp_t expected,
                              input div_resp_t actual);
    if (actual !== expected) begin
      abort_run($sformatf("Fail at %0t: %s a=%h b=%h expected rem=%h quot=%h got rem=%h quot=%h",
                          $time, r.fn.name(), r.a, r.b, expected.rem, expected.quot,
                          actual.rem, actual.quot));
    end
  endtask

  task automatic compare_latency(input int measured, input int expected);
    if (measured != expected) begin
      abort_run($sformatf("Fail at %0t: resp_val after %0d edges, expected %0d",
                          $time, measured, expected));
    end
  endtask

  task automatic compare_signs(input div_req_t r, input div_signs_t expected,
                               input div_signs_t actual);
    if (actual !== expected) begin
      abort_run($sformatf("Fail at %0t: a=%h b=%h sign flags expected %b got %b",
                          $time, r.a, r.b, expected, actual));
    end
  endtask

  // --------------------
  // one division through both handshakes
  // --------------------

  task automatic run_div(input div_req_t r, input int stall_cycles, output div_resp_t got);
    int edges;
    @(negedge clk);
    req     = r;
    req_val = 1'b1;
    while (!req_rdy) @(negedge clk);
    // next rising edge accepts
    @(negedge clk);
    req_val = 1'b0;
    // scramble the request, the unit must have latched what it needs
    req = make_req(random_fn(), $urandom, $urandom);
    // accepting edge counts as the first
    edges = 1;
    while (!resp_val) begin
      if (req_rdy) abort_run("req_rdy rose while a division was in flight");
      @(negedge clk);
      edges++;
    end
    compare_latency(edges, step_count + 1);
    for (int i = 0; i < stall_cycles; i++) begin
      @(negedge clk);
      if (!resp_val || req_rdy) abort_run("handshake changed while the response was stalled");
    end
    got      = resp;
    resp_rdy = 1'b1;
    @(negedge clk);
    resp_rdy = 1'b0;
    if (resp_val || !req_rdy) abort_run("divider did not return to idle after the transfer");
  endtask

  task automatic check_op(input div_req_t r, input int stall_cycles, output div_resp_t got);
    run_div(r, stall_cycles, got);
    compare_resp(r, model_div(r), got);
  endtask

  // --------------------
  // directed tests
  // --------------------

  task automatic test_unsigned();
    div_resp_t got;
    check_op(make_req(fn_unsigned, 32'd100, 32'd7), 0, got);
    check_op(make_req(fn_unsigned, 32'd7, 32'd7), 0, got);
    check_op(make_req(fn_unsigned, 32'd3, 32'd10), 0, got);
    check_op(make_req(fn_unsigned, 32'd0, 32'd5), 0, got);
    check_op(make_req(fn_unsigned, 32'hffffffff, 32'd1), 0, got);
    check_op(make_req(fn_unsigned, 32'hffffffff, 32'h10), 0, got);
    check_op(make_req(fn_unsigned, 32'h80000000, 32'd3), 0, got);
    check_op(make_req(fn_unsigned, 32'hdeadbeef, 32'h12345), 0, got);
  endtask

  // quotient sign from the xor, remainder sign from the dividend
  task automatic check_signed(input logic [data_width-1:0] a, input logic [data_width-1:0] b);
    div_req_t   r;
    div_resp_t  expected;
    div_resp_t  got;
    div_signs_t exp_s;
    div_signs_t got_s;
    r        = make_req(fn_signed, a, b);
    expected = model_div(r);
    run_div(r, 0, got);
    exp_s.quot_neg = (expected.quot != '0) && (a[data_width-1] ^ b[data_width-1]);
    exp_s.rem_neg  = (expected.rem != '0) && a[data_width-1];
    got_s.quot_neg = got.quot[data_width-1];
    got_s.rem_neg  = got.rem[data_width-1];
    compare_signs(r, exp_s, got_s);
    compare_resp(r, expected, got);
  endtask

  task automatic test_signed();
    check_signed(32'd100, 32'd7);
    check_signed(-32'sd100, 32'd7);
    check_signed(32'd100, -32'sd7);
    check_signed(-32'sd100, -32'sd7);
    check_signed(-32'sd42, 32'd6);
    check_signed(32'd42, -32'sd6);
    check_signed(-32'sd42, -32'sd6);
    check_signed(32'h7fffffff, -32'sd2);
  endtask

  // expected values written straight from the corner-case rules
  task automatic test_corner();
    div_req_t  r;
    div_resp_t got;
    r = make_req(fn_unsigned, 32'd1234, 32'd0);
    run_div(r, 0, got);
    compare_resp(r, make_resp(32'd1234, 32'hffffffff), got);
    r = make_req(fn_signed, -32'sd1234, 32'd0);
    run_div(r, 0, got);
    compare_resp(r, make_resp(-32'sd1234, 32'd1), got);
    r = make_req(fn_signed, 32'd1234, 32'd0);
    run_div(r, 0, got);
    compare_resp(r, make_resp(32'd1234, 32'hffffffff), got);
    r = make_req(fn_signed, 32'h80000000, 32'hffffffff);
    run_div(r, 0, got);
    compare_resp(r, make_resp(32'd0, 32'h80000000), got);
    r = make_req(fn_unsigned, 32'h80000000, 32'hffffffff);
    run_div(r, 0, got);
    compare_resp(r, make_resp(32'h80000000, 32'd0), got);
  endtask

  task automatic test_backpressure();
    div_resp_t got;
    check_op(make_req(fn_signed, -32'sd99999, 32'd313), 5, got);
    check_op(make_req(fn_unsigned, 32'hcafef00d, 32'h3), max_stall, got);
  endtask

  task automatic test_random();
    div_resp_t got;
    int        shift;
    for (int i = 0; i < 200; i++) begin
      // shrink the divisor now and then for larger quotients
      shift = $urandom_range(31, 0);
      check_op(make_req(random_fn(), $urandom, $urandom >> shift),
               $urandom_range(max_stall, 0), got);
    end
  endtask

  // --------------------
  // main sequence
  // --------------------

  initial begin
    void'($urandom(seed));
    reset    = 1'b1;
    req_val  = 1'b0;
    resp_rdy = 1'b0;
    req      = '0;
    repeat (reset_cycles) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    if (!req_rdy || resp_val) abort_run("handshake outputs not idle after reset");
    test_unsigned();
    test_signed();
    test_corner();
    test_backpressure();
    test_random();
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

//--- int_div_iterative.f
hw/int_div_pkg.sv
hw/int_div_ctrl.sv
hw/div_operand_prep.sv
hw/div_step_unit.sv
hw/div_result_fix.sv
hw/int_div_iterative.sv
verif/int_div_assertions.sv
verif/int_div_iterative_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = int_div_iterative_tb
FILELIST  = int_div_iterative.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
